// File: all.f
+incdir+rtl
rtl/pio_pkg.sv
rtl/sample_fifo.sv
rtl/sample_collector.sv
rtl/pio_channel.sv
rtl/axil_reg_slave.sv
rtl/pio_top.sv
sim/pio_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module pio_tb -f all.f -o pio_sim

# The simulator exits nonzero on a fatal check, the grep below still decides.
output="$(./obj_dir/pio_sim 2>&1 || true)"
echo "$output"

if echo "$output" | grep -q "^ALL CHECKS PASSED$"; then
  exit 0
fi
exit 1

// File: sim/pio_tb.sv
`include "pio_cfg.svh"

module pio_tb
  import pio_pkg::*;
();

  localparam int NUM        = `PIO_NUM_PINS;
  localparam int DEPTH      = `PIO_FIFO_DEPTH;
  localparam int MAX_CYCLES = 6000;

  logic           clk;
  logic           reset;
  logic [7:0]     awaddr;
  logic           awvalid;
  logic           awready;
  logic [31:0]    wdata;
  logic           wvalid;
  logic           wready;
  logic [1:0]     bresp;
  logic           bvalid;
  logic           bready;
  logic [7:0]     araddr;
  logic           arvalid;
  logic           arready;
  logic [31:0]    rdata;
  logic [1:0]     rresp;
  logic           rvalid;
  logic           rready;
  logic [NUM-1:0] pin_in;
  logic [NUM-1:0] pin_out;
  logic [NUM-1:0] pin_oe;

  int   seed = 32'h4d4213f8;
  int   cycles = 0;
  // Next expected capture number and held level per channel.
  int   exp_count [NUM];
  logic exp_level [NUM];
  int   words_seen [NUM];

  pio_top pio_top_i (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Simulation hung: still running after %0d clock cycles", cycles);
      $display("CHECKS FAILED");
      $fatal(1);
    end
  end

  task automatic report_error(input string msg);
    $display("ERR %0t: %s", $time, msg);
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  // Read data holds while the host stalls.
  assert property (@(posedge clk) disable iff (reset)
    rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
    else report_error("read response changed while rready was low");

  assert property (@(posedge clk) disable iff (reset) bvalid && !bready |=> bvalid)
    else report_error("write response dropped before bready");

  // Address and data are accepted together.
  assert property (@(posedge clk) disable iff (reset) wready == awready)
    else report_error("wready and awready did not pulse together");

  assert property (@(posedge clk) disable iff (reset) (pin_out & ~pin_oe) == '0)
    else report_error("pin_out high while pin_oe is low");

  function automatic logic [7:0] reg_addr(input int chan, input logic [1:0] sel);
    return {chan[3:0], sel, 2'b00};
  endfunction

  function automatic int rand_range(input int lo, input int hi);
    return lo + int'({$random(seed)} % (hi - lo + 1));
  endfunction

  task automatic axi_write(input logic [7:0] addr, input logic [31:0] data);
    awaddr  = addr;
    wdata   = data;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    while (!awready || !wready) begin
      @(negedge clk);
    end
    @(negedge clk);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    while (!bvalid) begin
      @(negedge clk);
    end
    assert (bresp == `PIO_RESP_OKAY)
      else report_error($sformatf("write to %h answered %b", addr, bresp));
    // The response waits one cycle for bready.
    @(negedge clk);
    bready = 1'b1;
    @(negedge clk);
    bready = 1'b0;
  endtask

  // Hold is the number of cycles rready stays low once rvalid is up.
  task automatic axi_read(input logic [7:0] addr, input int hold,
                          output logic [31:0] data, output logic [1:0] resp);
    araddr  = addr;
    arvalid = 1'b1;
    while (!arready) begin
      @(negedge clk);
    end
    @(negedge clk);
    arvalid = 1'b0;
    while (!rvalid) begin
      @(negedge clk);
    end
    repeat (hold) @(negedge clk);
    data   = rdata;
    resp   = rresp;
    rready = 1'b1;
    @(negedge clk);
    rready = 1'b0;
  endtask

  task automatic read_status(input int ch, input int hold, output logic [3:0] st);
    logic [31:0] data;
    logic [1:0]  resp;
    axi_read(reg_addr(ch, `PIO_REG_STATUS), hold, data, resp);
    assert (resp == `PIO_RESP_OKAY && data[31:4] == '0)
      else report_error($sformatf("status of channel %0d read %h/%b", ch, data, resp));
    st = data[3:0];
  endtask

  // One FIFO data read checked against the channel's expected sequence.
  task automatic pop_check(output bit got);
    logic [31:0]  data;
    logic [1:0]   resp;
    sample_word_u w;
    int           ch;
    axi_read(reg_addr(15, `PIO_GREG_FIFO_DATA), 0, data, resp);
    got   = (resp == `PIO_RESP_OKAY);
    w.raw = data;
    ch    = int'(w.fields.channel);
    if (!got) begin
      assert (resp == `PIO_RESP_SLVERR && data == 32'd0)
        else report_error($sformatf("empty FIFO read gave %h/%b", data, resp));
    end else begin
      assert (ch < NUM) else report_error($sformatf("sample from channel %0d", ch));
      assert (w.fields.level == exp_level[ch] && w.fields.reserved == 7'd0)
        else report_error($sformatf("bad level or reserved bits in sample %h", data));
      assert (int'(w.fields.count) == exp_count[ch])
        else report_error($sformatf("channel %0d count %0d, expected %0d",
                                    ch, w.fields.count, exp_count[ch]));
      exp_count[ch]++;
      words_seen[ch]++;
    end
  endtask

  task automatic drain_fifo();
    bit got;
    got = 1'b1;
    while (got) begin
      pop_check(got);
    end
  endtask

  task automatic start_stream(input int ch, input int rate);
    exp_level[ch]  = pin_in[ch];
    exp_count[ch]  = 1;
    words_seen[ch] = 0;
    axi_write(reg_addr(ch, `PIO_REG_SAMPLE_RATE), 32'(rate));
    axi_write(reg_addr(ch, `PIO_REG_CMD), `PIO_CMD_INPUT_STREAM);
  endtask

  task automatic stop_all();
    for (int i = 0; i < NUM; i++) begin
      axi_write(reg_addr(i, `PIO_REG_CMD), `PIO_CMD_STOP);
    end
    repeat (8) @(negedge clk);
  endtask

  // NCO output toggles every 2^(31-k) cycles for a step of 2^k.
  task automatic check_output(input int ch);
    int   k;
    int   half;
    int   run;
    int   changes;
    logic prev;
    k    = rand_range(27, 31);
    half = 1 << (31 - k);
    axi_write(reg_addr(ch, `PIO_REG_NCO_STEP), 32'd1 << k);
    axi_write(reg_addr(ch, `PIO_REG_CMD), `PIO_CMD_START_OUTPUT);
    assert (pin_oe[ch]) else report_error($sformatf("pin_oe[%0d] low in output mode", ch));
    prev    = pin_out[ch];
    run     = 0;
    changes = 0;
    while (changes < 5) begin
      @(negedge clk);
      run++;
      if (pin_out[ch] != prev) begin
        changes++;
        assert (changes == 1 || run == half)
          else report_error($sformatf("pin %0d held %0d cycles, expected %0d", ch, run, half));
        run  = 0;
        prev = pin_out[ch];
      end
    end
    axi_write(reg_addr(ch, `PIO_REG_CMD), `PIO_CMD_STOP);
    assert (!pin_oe[ch] && !pin_out[ch]) else report_error("pin still driven after STOP");
  endtask

  initial begin
    logic [31:0] data;
    logic [1:0]  resp;
    logic [3:0]  st;
    bit          got;
    int          ch;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    pin_in  = '0;
    reset   = 1'b1;
    repeat (4) @(negedge clk);
    reset = 1'b0;

    // Idle state after reset.
    assert (pin_oe == '0 && !bvalid && !rvalid) else report_error("outputs active after reset");
    axi_read(reg_addr(15, `PIO_GREG_FIFO_LEVEL), 0, data, resp);
    assert (data == 32'd0 && resp == `PIO_RESP_OKAY) else report_error("FIFO not empty after reset");
    axi_read(reg_addr(15, `PIO_GREG_FIFO_DATA), 0, data, resp);
    assert (data == 32'd0 && resp == `PIO_RESP_SLVERR) else report_error("empty read not SLVERR");

    for (int i = 0; i < NUM; i++) begin
      check_output(i);
    end

    // Single channel stream.
    pin_in = NUM'($random(seed));
    ch     = rand_range(0, NUM - 1);
    start_stream(ch, rand_range(3, 6));
    read_status(ch, 0, st);
    assert (st[0] && !st[1] && st[3] == pin_in[ch]) else report_error("stream status wrong");
    while (words_seen[ch] < 6) begin
      pop_check(got);
    end
    stop_all();
    drain_fifo();

    // All channels stream at once.
    pin_in = NUM'($random(seed));
    for (int i = 0; i < NUM; i++) begin
      start_stream(i, rand_range(3, 6));
    end
    repeat (32) pop_check(got);
    stop_all();
    drain_fifo();
    for (int i = 0; i < NUM; i++) begin
      assert (words_seen[i] >= 2)
        else report_error($sformatf("channel %0d got only %0d words", i, words_seen[i]));
    end

    // Unread FIFO fills up and the channel overruns.
    ch = rand_range(0, NUM - 1);
    start_stream(ch, 3);
    data = '0;
    while (data != 32'(DEPTH)) begin
      axi_read(reg_addr(15, `PIO_GREG_FIFO_LEVEL), 0, data, resp);
    end
    st = '0;
    while (!st[2]) begin
      read_status(ch, 0, st);
    end
    axi_write(reg_addr(ch, `PIO_REG_SAMPLE_RATE), 32'd50);
    axi_write(reg_addr(ch, `PIO_REG_CMD), `PIO_CMD_INPUT_STREAM);
    read_status(ch, 0, st);
    assert (st[0] && !st[2]) else report_error("overrun not cleared by INPUT_STREAM");
    stop_all();
    drain_fifo();

    // Unmapped and read-only writes change nothing.
    axi_write(reg_addr(NUM, `PIO_REG_CMD), `PIO_CMD_START_OUTPUT);
    axi_write(reg_addr(15, `PIO_GREG_FIFO_LEVEL), 32'hffff_ffff);
    axi_write(reg_addr(ch, `PIO_REG_STATUS), 32'hf);
    assert (pin_oe == '0) else report_error("unmapped write enabled a pin");
    for (int i = 0; i < NUM; i++) begin
      read_status(i, rand_range(1, 5), st);
      assert (st[1:0] == 2'b00 && st[3] == pin_in[i])
        else report_error($sformatf("channel %0d status %b after unmapped writes", i, st));
    end
    axi_read(reg_addr(15, 2'd2), rand_range(1, 5), data, resp);
    assert (data == 32'd0 && resp == `PIO_RESP_OKAY) else report_error("unmapped read not 0/OKAY");
    axi_read(reg_addr(15, `PIO_GREG_FIFO_LEVEL), rand_range(1, 5), data, resp);
    assert (data == 32'd0) else report_error("FIFO level changed by a write");

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

// File: rtl/pio_top.sv
`include "pio_cfg.svh"

module pio_top
  import pio_pkg::*;
(
  input  logic                     clk,
  input  logic                     reset,
  input  logic [`PIO_ADDR_W-1:0]   awaddr,
  input  logic                     awvalid,
  output logic                     awready,
  input  logic [31:0]              wdata,
  input  logic                     wvalid,
  output logic                     wready,
  output logic [1:0]               bresp,
  output logic                     bvalid,
  input  logic                     bready,
  input  logic [`PIO_ADDR_W-1:0]   araddr,
  input  logic                     arvalid,
  output logic                     arready,
  output logic [31:0]              rdata,
  output logic [1:0]               rresp,
  output logic                     rvalid,
  input  logic                     rready,
  input  logic [`PIO_NUM_PINS-1:0] pin_in,
  output logic [`PIO_NUM_PINS-1:0] pin_out,
  output logic [`PIO_NUM_PINS-1:0] pin_oe
);

  logic [`PIO_NUM_PINS-1:0]         chan_wr;
  logic [1:0]                       reg_sel;
  logic [31:0]                      wr_data;
  logic [4*`PIO_NUM_PINS-1:0]       chan_status;
  logic [`PIO_NUM_PINS-1:0]         sample_valid;
  logic [`PIO_NUM_PINS-1:0]         sample_ready;
  sample_word_u [`PIO_NUM_PINS-1:0] sample_words;
  logic                             push;
  sample_word_u                     push_word;
  logic [31:0]                      fifo_head;
  logic                             fifo_empty;
  logic                             fifo_full;
  logic [3:0]                       fifo_level;
  logic                             pop;

  axil_reg_slave slave_i (
    .clk(clk), .reset(reset),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wvalid(wvalid), .wready(wready),
    .bresp(bresp), .bvalid(bvalid), .bready(bready),
    .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
    .chan_wr(chan_wr), .reg_sel(reg_sel), .wr_data(wr_data),
    .chan_status(chan_status),
    .fifo_head(fifo_head), .fifo_empty(fifo_empty), .fifo_level(fifo_level),
    .pop(pop)
  );

  // One pin controller per pin.
  for (genvar g = 0; g < `PIO_NUM_PINS; g++) begin : g_chan
    pio_channel #(.CHANNEL(g)) channel_i (
      .clk(clk), .reset(reset),
      .wr(chan_wr[g]), .reg_sel(reg_sel), .wr_data(wr_data),
      .pin_in(pin_in[g]), .sample_ready(sample_ready[g]),
      .pin_out(pin_out[g]), .pin_oe(pin_oe[g]),
      .sample_valid(sample_valid[g]), .sample_word(sample_words[g]),
      .status(chan_status[4*g +: 4])
    );
  end

  sample_collector collector_i (
    .clk(clk), .reset(reset),
    .sample_valid(sample_valid), .sample_words(sample_words), .full(fifo_full),
    .sample_ready(sample_ready), .push(push), .push_data(push_word)
  );

  sample_fifo fifo_i (
    .clk(clk), .reset(reset),
    .push(push), .push_data(push_word.raw), .pop(pop),
    .head(fifo_head), .empty(fifo_empty), .full(fifo_full), .level(fifo_level)
  );

endmodule

// File: rtl/axil_reg_slave.sv
`include "pio_cfg.svh"

module axil_reg_slave (
  input  logic                       clk,
  input  logic                       reset,
  input  logic [`PIO_ADDR_W-1:0]     awaddr,
  input  logic                       awvalid,
  output logic                       awready,
  input  logic [31:0]                wdata,
  input  logic                       wvalid,
  output logic                       wready,
  output logic [1:0]                 bresp,
  output logic                       bvalid,
  input  logic                       bready,
  input  logic [`PIO_ADDR_W-1:0]     araddr,
  input  logic                       arvalid,
  output logic                       arready,
  output logic [31:0]                rdata,
  output logic [1:0]                 rresp,
  output logic                       rvalid,
  input  logic                       rready,
  output logic [`PIO_NUM_PINS-1:0]   chan_wr,
  output logic [1:0]                 reg_sel,
  output logic [31:0]                wr_data,
  input  logic [4*`PIO_NUM_PINS-1:0] chan_status,
  input  logic [31:0]                fifo_head,
  input  logic                       fifo_empty,
  input  logic [3:0]                 fifo_level,
  output logic                       pop
);

  logic [3:0]  wr_chan;
  logic [1:0]  wr_reg;
  logic [3:0]  rd_chan;
  logic [1:0]  rd_reg;
  logic        wr_accept;
  logic        wr_hs;
  logic        rd_hs;
  logic [31:0] rd_word;
  logic [1:0]  rd_resp;
  logic        fifo_rd;

  // Address bits 7..4 pick the channel, bits 3..2 the register.
  assign wr_chan = awaddr[7:4];
  assign wr_reg  = awaddr[3:2];
  assign rd_chan = araddr[7:4];
  assign rd_reg  = araddr[3:2];

  // Address and data are taken together in one cycle.
  assign awready = wr_accept;
  assign wready  = wr_accept;
  assign wr_hs   = wr_accept && awvalid && wvalid;
  assign rd_hs   = arready && arvalid;

  // Writes always succeed, unmapped ones are dropped.
  assign bresp = `PIO_RESP_OKAY;

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_accept <= 1'b0;
      bvalid    <= 1'b0;
      chan_wr   <= '0;
      arready   <= 1'b0;
      rvalid    <= 1'b0;
    end else begin
      wr_accept <= awvalid && wvalid && !bvalid && !wr_accept;
      if (wr_hs) begin
        bvalid <= 1'b1;
      end else if (bready) begin
        bvalid <= 1'b0;
      end
      // Status is read-only, so it gets no strobe.
      for (int i = 0; i < `PIO_NUM_PINS; i++) begin
        chan_wr[i] <= wr_hs && (wr_chan == i) && (wr_reg != `PIO_REG_STATUS);
      end

      arready <= arvalid && !rvalid && !arready;
      if (rd_hs) begin
        rvalid <= 1'b1;
      end else if (rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_hs) begin
      reg_sel <= wr_reg;
      wr_data <= wdata;
    end
  end

  // Read decode.
  always_comb begin
    rd_word = '0;
    rd_resp = `PIO_RESP_OKAY;
    fifo_rd = 1'b0;
    if (rd_chan == `PIO_GLOBAL_CHAN) begin
      if (rd_reg == `PIO_GREG_FIFO_DATA) begin
        if (fifo_empty) begin
          rd_resp = `PIO_RESP_SLVERR;
        end else begin
          rd_word = fifo_head;
          fifo_rd = 1'b1;
        end
      end else if (rd_reg == `PIO_GREG_FIFO_LEVEL) begin
        rd_word = {28'd0, fifo_level};
      end
    end else if ((rd_chan < `PIO_NUM_PINS) && (rd_reg == `PIO_REG_STATUS)) begin
      rd_word = {28'd0, chan_status[rd_chan*4 +: 4]};
    end
  end

  // Data is held until the host takes it.
  always_ff @(posedge clk) begin
    if (rd_hs) begin
      rdata <= rd_word;
      rresp <= rd_resp;
    end
  end

  // Head word was latched above, drop it from the FIFO now.
  assign pop = rd_hs && fifo_rd;

endmodule

// File: rtl/pio_channel.sv
`include "pio_cfg.svh"

module pio_channel
  import pio_pkg::*;
#(
  parameter int CHANNEL = 0
) (
  input  logic         clk,
  input  logic         reset,
  input  logic         wr,
  input  logic [1:0]   reg_sel,
  input  logic [31:0]  wr_data,
  input  logic         pin_in,
  input  logic         sample_ready,
  output logic         pin_out,
  output logic         pin_oe,
  output logic         sample_valid,
  output sample_word_u sample_word,
  output logic [3:0]   status
);

  localparam logic [1:0] MODE_IDLE   = 2'd0;
  localparam logic [1:0] MODE_OUTPUT = 2'd1;
  localparam logic [1:0] MODE_STREAM = 2'd2;

  logic [1:0]  mode;
  logic [31:0] nco_step;
  logic [15:0] sample_rate;
  logic [15:0] rate_eff;
  logic [31:0] phase;
  logic [15:0] rate_cnt;
  logic [15:0] sample_count;
  logic        overrun;
  logic        cmd_wr;
  logic        cmd_out;
  logic        cmd_stream;
  logic        cmd_stop;
  logic        cmd_any;
  logic        tick;
  logic        pending;
  logic        capture;

  assign cmd_wr     = wr && (reg_sel == `PIO_REG_CMD);
  assign cmd_out    = cmd_wr && (wr_data == `PIO_CMD_START_OUTPUT);
  assign cmd_stream = cmd_wr && (wr_data == `PIO_CMD_INPUT_STREAM);
  assign cmd_stop   = cmd_wr && (wr_data == `PIO_CMD_STOP);
  assign cmd_any    = cmd_out || cmd_stream || cmd_stop;

  // A rate of 0 behaves like 1.
  assign rate_eff = (sample_rate == 16'd0) ? 16'd1 : sample_rate;

  // Capture when the down counter reaches 1, unless a command lands this cycle.
  assign tick    = (mode == MODE_STREAM) && (rate_cnt <= 16'd1) && !cmd_any;
  assign pending = sample_valid && !sample_ready;
  assign capture = tick && !pending;

  always_ff @(posedge clk) begin
    if (reset) begin
      mode         <= MODE_IDLE;
      nco_step     <= '0;
      sample_rate  <= '0;
      phase        <= '0;
      rate_cnt     <= '0;
      sample_count <= '0;
      overrun      <= 1'b0;
      sample_valid <= 1'b0;
    end else begin
      if (wr && (reg_sel == `PIO_REG_NCO_STEP)) begin
        nco_step <= wr_data;
      end
      if (wr && (reg_sel == `PIO_REG_SAMPLE_RATE)) begin
        sample_rate <= wr_data[15:0];
      end

      // Mode follows the command directly.
      if (cmd_out) begin
        mode <= MODE_OUTPUT;
      end else if (cmd_stream) begin
        mode <= MODE_STREAM;
      end else if (cmd_stop) begin
        mode <= MODE_IDLE;
      end

      // NCO restarts from zero on every start command.
      if (cmd_out) begin
        phase <= '0;
      end else if (mode == MODE_OUTPUT) begin
        phase <= phase + nco_step;
      end

      if (cmd_stream || tick) begin
        rate_cnt <= rate_eff;
      end else if (mode == MODE_STREAM) begin
        rate_cnt <= rate_cnt - 16'd1;
      end

      // STOP keeps count and overrun for the host to inspect.
      if (cmd_out || cmd_stream) begin
        sample_count <= '0;
        overrun      <= 1'b0;
      end else if (capture) begin
        sample_count <= sample_count + 16'd1;
      end else if (tick) begin
        overrun <= 1'b1;
      end

      if (capture) begin
        sample_valid <= 1'b1;
      end else if (sample_ready) begin
        sample_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      sample_word.fields.count    <= sample_count + 16'd1;
      sample_word.fields.channel  <= 8'(CHANNEL);
      sample_word.fields.reserved <= '0;
      sample_word.fields.level    <= pin_in;
    end
  end

  assign pin_oe  = (mode == MODE_OUTPUT);
  assign pin_out = (mode == MODE_OUTPUT) && phase[31];
  assign status  = {pin_in, overrun, mode == MODE_OUTPUT, mode == MODE_STREAM};

endmodule

// File: rtl/sample_collector.sv
`include "pio_cfg.svh"

module sample_collector
  import pio_pkg::*;
(
  input  logic                             clk,
  input  logic                             reset,
  input  logic [`PIO_NUM_PINS-1:0]         sample_valid,
  input  sample_word_u [`PIO_NUM_PINS-1:0] sample_words,
  input  logic                             full,
  output logic [`PIO_NUM_PINS-1:0]         sample_ready,
  output logic                             push,
  output sample_word_u                     push_data
);

  localparam int N     = `PIO_NUM_PINS;
  localparam int PTR_W = (N > 1) ? $clog2(N) : 1;

  logic [PTR_W-1:0] last_grant;
  logic [PTR_W-1:0] pick;
  logic             pick_found;
  logic             out_valid;
  logic             can_take;
  logic             grant;

  // Round-robin search, starting after the last granted channel.
  always_comb begin
    int idx;
    pick       = last_grant;
    pick_found = 1'b0;
    for (int i = 1; i <= N; i++) begin
      idx = (int'(last_grant) + i) % N;
      if (!pick_found && sample_valid[idx]) begin
        pick_found = 1'b1;
        pick       = PTR_W'(idx);
      end
    end
  end

  // The output register frees up in the same cycle it pushes.
  assign push     = out_valid && !full;
  assign can_take = !out_valid || !full;
  assign grant    = pick_found && can_take;

  always_comb begin
    sample_ready       = '0;
    sample_ready[pick] = grant;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid  <= 1'b0;
      last_grant <= PTR_W'(N - 1);
    end else if (grant) begin
      out_valid  <= 1'b1;
      last_grant <= pick;
    end else if (push) begin
      out_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (grant) begin
      push_data <= sample_words[pick];
    end
  end

endmodule

// File: rtl/sample_fifo.sv
`include "pio_cfg.svh"

module sample_fifo (
  input  logic        clk,
  input  logic        reset,
  input  logic        push,
  input  logic [31:0] push_data,
  input  logic        pop,
  output logic [31:0] head,
  output logic        empty,
  output logic        full,
  output logic [3:0]  level
);

  localparam int DEPTH = `PIO_FIFO_DEPTH;
  localparam int AW    = $clog2(DEPTH);

  logic [31:0]   mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  // Occupancy, 0 to DEPTH.
  logic [3:0]    count;
  logic          do_push;
  logic          do_pop;

  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // Pointers wrap naturally, depth is a power of two.
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + AW'(1);
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + AW'(1);
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 4'd1;
        2'b01:   count <= count - 4'd1;
        default: count <= count;
      endcase
    end
  end

  // First word falls through to the head.
  assign head  = mem[rd_ptr];
  assign empty = (count == 4'd0);
  assign full  = (count == DEPTH);
  assign level = count;

endmodule

// File: rtl/pio_pkg.sv
`include "pio_cfg.svh"

package pio_pkg;

  // One captured sample.
  // The channel builds it field by field, the FIFO and the bus only see the raw word.
  typedef union packed {
    logic [31:0] raw;
    struct packed {
      // Capture number, first capture after a start command is 1.
      logic [15:0] count;
      logic [7:0]  channel;
      // Always zero.
      logic [6:0]  reserved;
      // Pin level at capture time.
      logic        level;
    } fields;
  } sample_word_u;

endpackage

// File: rtl/pio_cfg.svh
`ifndef PIO_CFG_SVH
`define PIO_CFG_SVH

// Sizes. At most 15 channels, since channel select 15 is the global page.
`define PIO_NUM_PINS          4
`define PIO_FIFO_DEPTH        8
`define PIO_ADDR_W            8
`define PIO_GLOBAL_CHAN       4'hf

// Register selects, from address bits 3..2.
`define PIO_REG_CMD           2'd0
`define PIO_REG_NCO_STEP      2'd1
`define PIO_REG_SAMPLE_RATE   2'd2
`define PIO_REG_STATUS        2'd3
`define PIO_GREG_FIFO_DATA    2'd0
`define PIO_GREG_FIFO_LEVEL   2'd1

// Command codes written to the command register.
`define PIO_CMD_START_OUTPUT  32'd1
`define PIO_CMD_INPUT_STREAM  32'd3
`define PIO_CMD_STOP          32'd5

// AXI response codes.
`define PIO_RESP_OKAY         2'b00
`define PIO_RESP_SLVERR       2'b10

`endif
